/* run.sh */
#!/usr/bin/env bash
# Builds and runs the ALU testbench with Verilator for Mode 0 and Mode 3

runMode() {
  local mode=$1
  rm -f "sim_mode${mode}.log"
  verilator --binary --timing --timescale 1ns/1ns -f vlog.f --top-module tbAluUnit \
    -GMode="${mode}" --Mdir "obj_mode${mode}" -o "simMode${mode}" &&
    "./obj_mode${mode}/simMode${mode}" | tee "sim_mode${mode}.log" &&
    grep -q "Result: PASSED" "sim_mode${mode}.log"
}

runMode 0 && runMode 3 && echo "Both modes ran clean" || {
  echo "Simulation did not pass, see sim_mode*.log"
  exit 1
}

/* verification/aluModel.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the ALU, expected q and flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Sign, zero, parity and the two undocumented bits of a result
function automatic aluPkg::byte_t resultFlags(input aluPkg::byte_t q, input aluPkg::byte_t f);
  aluPkg::byte_t o;
  o = f;
  o[aluPkg::flagS] = q[7];
  o[aluPkg::flagZ] = (q == 8'h00);
  o[aluPkg::flagP] = ~(^q);  // Even parity
  o[aluPkg::flagX] = q[3];
  o[aluPkg::flagY] = q[5];
  return o;
endfunction

function automatic aluPkg::aluResult_t aluModel(input aluPkg::aluReq_t r, input int mode);
  aluPkg::aluResult_t o;
  aluPkg::byte_t a;
  aluPkg::byte_t b;
  aluPkg::byte_t f;
  aluPkg::byte_t q;
  aluPkg::byte_t m;
  aluPkg::byte_t corr;
  logic [2:0] k;
  logic c;
  logic h;
  int cin;
  int full;
  int low;
  a = r.busA;
  b = r.busB;
  f = r.flagsIn;
  k = r.ir[5:3];
  m = 8'h01 << k;
  q = 8'h00;
  cin = (r.op == aluPkg::opAdc || r.op == aluPkg::opSbc) ? int'(f[aluPkg::flagC]) : 0;
  case (r.op)
    aluPkg::opAdd, aluPkg::opAdc: begin
      full = int'(a) + int'(b) + cin;
      low = int'(a[3:0]) + int'(b[3:0]) + cin;
      q = full[7:0];
      f[aluPkg::flagC] = (full > 255);
      f[aluPkg::flagH] = (low > 15);
      f[aluPkg::flagP] = (a[7] == b[7]) && (q[7] != a[7]);  // Signed overflow
      f[aluPkg::flagN] = 1'b0;
    end
    aluPkg::opSub, aluPkg::opSbc, aluPkg::opCp: begin
      full = int'(a) - int'(b) - cin;
      low = int'(a[3:0]) - int'(b[3:0]) - cin;
      q = full[7:0];
      f[aluPkg::flagC] = (full < 0);  // Borrow
      f[aluPkg::flagH] = (low < 0);
      f[aluPkg::flagP] = (a[7] != b[7]) && (q[7] != a[7]);
      f[aluPkg::flagN] = 1'b1;
    end
    aluPkg::opAnd, aluPkg::opXor, aluPkg::opOr: begin
      if (r.op == aluPkg::opAnd) q = a & b;
      else if (r.op == aluPkg::opXor) q = a ^ b;
      else q = a | b;
      f[aluPkg::flagH] = (r.op == aluPkg::opAnd);
      f[aluPkg::flagP] = ~(^q);
      f[aluPkg::flagN] = 1'b0;
      f[aluPkg::flagC] = 1'b0;
    end
    aluPkg::opShift: begin
      case (k)
        3'd0: q = {a[6:0], a[7]};  // RLC
        3'd1: q = {a[0], a[7:1]};
        3'd2: q = {a[6:0], f[aluPkg::flagC]};
        3'd3: q = {f[aluPkg::flagC], a[7:1]};
        3'd4: q = {a[6:0], 1'b0};
        3'd5: q = {a[7], a[7:1]};
        3'd6: q = (mode == 3) ? {a[3:0], a[7:4]} : {a[6:0], 1'b1};
        default: q = {1'b0, a[7:1]};
      endcase
      c = k[0] ? a[0] : a[7];  // Odd kinds shift right and lose bit 0
      if (k == 3'd6 && mode == 3)
        c = 1'b0;
      f = resultFlags(q, r.flagsIn);
      f[aluPkg::flagC] = c;
      f[aluPkg::flagH] = 1'b0;
      f[aluPkg::flagN] = 1'b0;
      if (r.iSet == 2'd0) begin  // Accumulator form keeps S, Z, P
        f[aluPkg::flagS] = r.flagsIn[aluPkg::flagS];
        f[aluPkg::flagZ] = r.flagsIn[aluPkg::flagZ];
        f[aluPkg::flagP] = r.flagsIn[aluPkg::flagP];
      end
    end
    aluPkg::opBit: begin
      q = b & m;
      f[aluPkg::flagS] = q[7];
      f[aluPkg::flagZ] = (q == 8'h00);
      f[aluPkg::flagP] = (q == 8'h00);
      f[aluPkg::flagH] = 1'b1;
      f[aluPkg::flagN] = 1'b0;
      f[aluPkg::flagX] = (r.ir[2:0] != 3'd6) && b[3];
      f[aluPkg::flagY] = (r.ir[2:0] != 3'd6) && b[5];
    end
    aluPkg::opSet: q = b | m;
    aluPkg::opRes: q = b & ~m;
    aluPkg::opDaa: begin
      corr = 8'h00;
      c = f[aluPkg::flagC];
      if (f[aluPkg::flagH] || a[3:0] > 4'd9) corr = 8'h06;
      if (f[aluPkg::flagC] || a > 8'h99) begin
        corr = corr | 8'h60;
        c = 1'b1;
      end
      if (f[aluPkg::flagN]) begin
        q = a - corr;
        h = f[aluPkg::flagH] && (a[3:0] < 4'd6);
      end else begin
        q = a + corr;
        h = (a[3:0] > 4'd9);
      end
      f = resultFlags(q, f);
      f[aluPkg::flagH] = h;
      f[aluPkg::flagC] = c;
    end
    aluPkg::opRld, aluPkg::opRrd: begin
      q = {a[7:4], (r.op == aluPkg::opRld) ? b[7:4] : b[3:0]};
      f = resultFlags(q, f);
      f[aluPkg::flagH] = 1'b0;
      f[aluPkg::flagN] = 1'b0;
    end
    default: q = 8'h00;  // Undefined opcode passes the flags
  endcase
  if (!r.op[3]) begin
    f[aluPkg::flagS] = q[7];
    f[aluPkg::flagZ] = (q == 8'h00) ? (r.z16 ? r.flagsIn[aluPkg::flagZ] : 1'b1) : 1'b0;
    f[aluPkg::flagX] = (r.op == aluPkg::opCp) ? b[3] : q[3];
    f[aluPkg::flagY] = (r.op == aluPkg::opCp) ? b[5] : q[5];
    if (r.arith16) begin
      f[aluPkg::flagS] = r.flagsIn[aluPkg::flagS];
      f[aluPkg::flagZ] = r.flagsIn[aluPkg::flagZ];
      f[aluPkg::flagP] = r.flagsIn[aluPkg::flagP];
    end
  end
  o.q = q;
  o.flags = f;
  return o;
endfunction

`endif

/* verification/tbAluUnit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU unit testbench with handshake driver,
// compare tasks and directed tests per op group
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tbAluUnit #(
  parameter int Mode = 0
);

  localparam int ackTimeout = 20;  // Cycles per handshake phase
  localparam aluPkg::byte_t szpMask = (8'h01 << aluPkg::flagS) | (8'h01 << aluPkg::flagZ)
                                      | (8'h01 << aluPkg::flagP);
  localparam aluPkg::byte_t zMask = 8'h01 << aluPkg::flagZ;

  logic               clk;
  logic               rst_i;
  logic               req_i;
  aluPkg::aluReq_t    cmd;
  logic               ack;
  aluPkg::aluResult_t res;
  logic [31:0]        lfsr;
  logic               hung;  // Set once the DUT stops answering
  int                 checks;
  int                 valErrors;
  int                 protoErrors;

  aluUnit #(
    .Mode (Mode)
  ) dut0 (
    .clk   (clk),
    .rst_i (rst_i),
    .req_i (req_i),
    .cmd_i (cmd),
    .ack_o (ack),
    .res_o (res)
  );

  `include "aluModel.svh"

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic aluPkg::aluReq_t randReq(input aluPkg::aluOp_t op);
    aluPkg::aluReq_t r;
    r = '0;
    r.op = op;
    r.ir = aluPkg::irField_t'(randBits(6));
    r.busA = aluPkg::byte_t'(randBits(8));
    r.busB = aluPkg::byte_t'(randBits(8));
    r.flagsIn = aluPkg::byte_t'(randBits(8));
    return r;
  endfunction

  task automatic checkBit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      valErrors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic checkByte(input string name, input aluPkg::byte_t got,
                           input aluPkg::byte_t exp);
    checks++;
    if (got !== exp) begin
      valErrors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic checkResult(input string name, input aluPkg::aluResult_t got,
                             input aluPkg::aluResult_t exp);
    checks++;
    if (got !== exp) begin
      valErrors++;
      $display("FAIL %s: got q=%h flags=%h, expected q=%h flags=%h",
               name, got.q, got.flags, exp.q, exp.flags);
    end
  endtask

  // Four-phase transaction that holds req for holdCycles after ack
  task automatic doOp(input aluPkg::aluReq_t r, input int holdCycles,
                      output aluPkg::aluResult_t got);
    int waited;
    got = '0;
    if (!hung) begin
      @(negedge clk);
      cmd = r;
      req_i = 1'b1;
      waited = 0;
      while (ack !== 1'b1 && waited < ackTimeout) begin
        @(negedge clk);
        waited++;
      end
      if (ack !== 1'b1) begin
        $display("Timeout: ack_o never rose for opcode %h", r.op);
        protoErrors++;
        hung = 1'b1;
      end else begin
        got = res;
        repeat (holdCycles) begin
          @(negedge clk);
          checkBit("ack_o while req_i held", ack, 1'b1);
          checkResult("res_o while req_i held", res, got);
        end
        req_i = 1'b0;
        waited = 0;
        while (ack !== 1'b0 && waited < ackTimeout) begin
          @(negedge clk);
          waited++;
        end
        if (ack !== 1'b0) begin
          $display("Timeout: ack_o stayed high after req_i fell");
          protoErrors++;
          hung = 1'b1;
        end
      end
      req_i = 1'b0;
    end
  endtask

  task automatic checkOp(input aluPkg::aluReq_t r);
    aluPkg::aluResult_t got;
    doOp(r, 0, got);
    if (!hung)
      checkResult($sformatf("res_o op %h ir %h iSet %h", r.op, r.ir, r.iSet), got,
                  aluModel(r, Mode));
  endtask

  task automatic testHandshake();
    aluPkg::aluReq_t    r;
    aluPkg::aluResult_t got;
    checkBit("ack_o after reset", ack, 1'b0);
    checkResult("res_o after reset", res, '0);
    r = randReq(aluPkg::opAdd);
    doOp(r, 4, got);
    if (!hung) begin
      checkResult("res_o held op", got, aluModel(r, Mode));
      @(negedge clk);  // One idle cycle with req_i low
      checkBit("ack_o idle after release", ack, 1'b0);
      checkResult("res_o after release", res, got);  // Kept until next capture
    end
  endtask

  task automatic testArith();
    for (int op = 0; op < 8; op++)
      repeat (24) checkOp(randReq(aluPkg::aluOp_t'(op)));
  endtask

  task automatic testGating();
    aluPkg::aluReq_t    r;
    aluPkg::aluResult_t got;
    for (int op = 0; op < 8; op++) begin
      repeat (4) begin
        r = randReq(aluPkg::aluOp_t'(op));
        r.arith16 = 1'b1;
        doOp(r, 0, got);
        if (!hung) begin
          checkByte("res_o.flags S Z P with arith16", got.flags & szpMask,
                    r.flagsIn & szpMask);
          checkResult("res_o with arith16", got, aluModel(r, Mode));
        end
      end
    end
    // Equal operands give a zero difference
    for (int z = 0; z < 2; z++) begin
      r = randReq(aluPkg::opSub);
      r.busB = r.busA;
      r.z16 = 1'b1;
      r.flagsIn[aluPkg::flagZ] = z[0];
      doOp(r, 0, got);
      if (!hung)
        checkByte("res_o.flags Z with z16", got.flags & zMask, r.flagsIn & zMask);
    end
  endtask

  task automatic testShift();
    aluPkg::aluReq_t    r;
    aluPkg::aluResult_t got;
    for (int set = 0; set < 2; set++) begin
      for (int kind = 0; kind < 8; kind++) begin
        repeat (6) begin
          r = randReq(aluPkg::opShift);
          r.ir[5:3] = kind[2:0];
          r.iSet = aluPkg::iSet_t'(set);
          checkOp(r);
        end
      end
    end
    r = randReq(aluPkg::opShift);
    r.ir[5:3] = 3'd6;
    r.iSet = 2'd1;
    r.busA = 8'hC3;
    doOp(r, 0, got);
    if (!hung) begin
      checkByte("res_o.q SLL slot", got.q, (Mode == 3) ? 8'h3C : 8'h87);
      checkBit("res_o.flags C SLL slot", got.flags[aluPkg::flagC], Mode != 3);
    end
  endtask

  task automatic testBitOps();
    aluPkg::aluReq_t r;
    for (int op = int'(aluPkg::opBit); op <= int'(aluPkg::opRes); op++) begin
      for (int idx = 0; idx < 8; idx++) begin
        for (int src = 0; src < 8; src++) begin
          r = randReq(aluPkg::aluOp_t'(op));
          r.ir = {idx[2:0], src[2:0]};
          checkOp(r);
        end
      end
    end
    repeat (8) checkOp(randReq(aluPkg::opRld));
    repeat (8) checkOp(randReq(aluPkg::opRrd));
    repeat (4) checkOp(randReq(4'hF));  // Undefined opcode
  endtask

  task automatic testDaa();
    aluPkg::aluReq_t r;
    for (int nhc = 0; nhc < 8; nhc++) begin
      repeat (12) begin
        r = randReq(aluPkg::opDaa);
        r.flagsIn[aluPkg::flagN] = nhc[2];
        r.flagsIn[aluPkg::flagH] = nhc[1];
        r.flagsIn[aluPkg::flagC] = nhc[0];
        checkOp(r);
      end
    end
  endtask

  initial begin
    rst_i = 1'b1;
    req_i = 1'b0;
    cmd = '0;
    lfsr = 32'h0cda_843c;
    hung = 1'b0;
    checks = 0;
    valErrors = 0;
    protoErrors = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;

    testHandshake();
    testArith();
    testGating();
    testShift();
    testBitOps();
    testDaa();

    $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
             checks, valErrors, protoErrors);
    if (valErrors == 0 && protoErrors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* verilog/aluArith.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arithmetic and logic group of the ALU
// Split-carry adder, overflow, parity, 16-bit gating
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module aluArith (
  input  aluPkg::aluReq_t    cmd_i,
  output aluPkg::aluResult_t res_o
);

  aluPkg::byte_t opB;
  aluPkg::byte_t sum;
  aluPkg::byte_t q;
  aluPkg::byte_t flags;
  logic          sub;
  logic          useCarry;
  logic          carryIn;
  logic          halfCarry;
  logic          carry7;
  logic          carryOut;
  logic          overflow;

  assign sub      = cmd_i.op[1];                    // SUB, SBC and CP
  assign useCarry = ~cmd_i.op[2] & cmd_i.op[0];     // Only ADC and SBC
  assign opB      = sub ? ~cmd_i.busB : cmd_i.busB;
  assign carryIn  = sub ^ (useCarry & cmd_i.flagsIn[aluPkg::flagC]);

  // One adder cut into 4/3/1 bit stages to expose H and carry into bit 7
  assign {halfCarry, sum[3:0]} = {1'b0, cmd_i.busA[3:0]} + {1'b0, opB[3:0]}
                                 + {4'b0, carryIn};
  assign {carry7, sum[6:4]}    = {1'b0, cmd_i.busA[6:4]} + {1'b0, opB[6:4]}
                                 + {3'b0, halfCarry};
  assign {carryOut, sum[7]}    = {1'b0, cmd_i.busA[7]} + {1'b0, opB[7]}
                                 + {1'b0, carry7};
  assign overflow = carryOut ^ carry7;

  always_comb begin
    flags = cmd_i.flagsIn;
    flags[aluPkg::flagN] = 1'b0;
    flags[aluPkg::flagC] = 1'b0;
    q = '0;
    case (cmd_i.op)
      aluPkg::opAdd, aluPkg::opAdc: begin
        q = sum;
        flags[aluPkg::flagC] = carryOut;
        flags[aluPkg::flagH] = halfCarry;
        flags[aluPkg::flagP] = overflow;
      end
      aluPkg::opSub, aluPkg::opSbc, aluPkg::opCp: begin
        q = sum;
        flags[aluPkg::flagN] = 1'b1;
        flags[aluPkg::flagC] = ~carryOut;  // Borrow
        flags[aluPkg::flagH] = ~halfCarry;
        flags[aluPkg::flagP] = overflow;
      end
      aluPkg::opAnd: begin
        q = cmd_i.busA & cmd_i.busB;
        flags[aluPkg::flagH] = 1'b1;
        flags[aluPkg::flagP] = ~(^q);
      end
      aluPkg::opXor: begin
        q = cmd_i.busA ^ cmd_i.busB;
        flags[aluPkg::flagH] = 1'b0;
        flags[aluPkg::flagP] = ~(^q);
      end
      aluPkg::opOr: begin
        q = cmd_i.busA | cmd_i.busB;
        flags[aluPkg::flagH] = 1'b0;
        flags[aluPkg::flagP] = ~(^q);
      end
      default: ;  // Other group, not selected by the core
    endcase

    // CP reports the undocumented bits of the operand
    flags[aluPkg::flagX] = (cmd_i.op == aluPkg::opCp) ? cmd_i.busB[3] : q[3];
    flags[aluPkg::flagY] = (cmd_i.op == aluPkg::opCp) ? cmd_i.busB[5] : q[5];
    flags[aluPkg::flagS] = q[7];
    if (q == 8'h00)
      flags[aluPkg::flagZ] = cmd_i.z16 ? cmd_i.flagsIn[aluPkg::flagZ] : 1'b1;
    else
      flags[aluPkg::flagZ] = 1'b0;

    if (cmd_i.arith16) begin
      flags[aluPkg::flagS] = cmd_i.flagsIn[aluPkg::flagS];
      flags[aluPkg::flagZ] = cmd_i.flagsIn[aluPkg::flagZ];
      flags[aluPkg::flagP] = cmd_i.flagsIn[aluPkg::flagP];
    end
  end

  assign res_o.q     = q;
  assign res_o.flags = flags;

endmodule

/* verilog/aluBitShift.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rotate/shift, BIT/SET/RES, DAA, nibble merge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module aluBitShift #(
  parameter int Mode = 0  // 3 puts the nibble swap in the SLL slot
) (
  input  aluPkg::aluReq_t    cmd_i,
  output aluPkg::aluResult_t res_o
);

  aluPkg::byte_t busA;
  aluPkg::byte_t busB;
  aluPkg::byte_t fIn;
  aluPkg::byte_t mask;
  aluPkg::byte_t shiftQ;
  aluPkg::byte_t q;
  aluPkg::byte_t flags;
  logic          shiftC;
  logic [8:0]    daaQ;
  logic          daaH;

  // S, Z, P, X and Y taken from a result byte
  function automatic aluPkg::byte_t resFlags(input aluPkg::byte_t res,
                                             input aluPkg::byte_t f);
    aluPkg::byte_t o;
    o = f;
    o[aluPkg::flagS] = res[7];
    o[aluPkg::flagZ] = (res == 8'h00);
    o[aluPkg::flagP] = ~(^res);
    o[aluPkg::flagX] = res[3];
    o[aluPkg::flagY] = res[5];
    return o;
  endfunction

  assign busA = cmd_i.busA;
  assign busB = cmd_i.busB;
  assign fIn  = cmd_i.flagsIn;
  assign mask = 8'd1 << cmd_i.ir[5:3];  // One-hot bit select

  always_comb begin
    shiftQ = {busA[6:0], busA[7]};  // RLC
    shiftC = busA[7];
    case (cmd_i.ir[5:3])
      3'd1: begin  // RRC
        shiftQ = {busA[0], busA[7:1]};
        shiftC = busA[0];
      end
      3'd2: shiftQ = {busA[6:0], fIn[aluPkg::flagC]};  // RL
      3'd3: begin  // RR
        shiftQ = {fIn[aluPkg::flagC], busA[7:1]};
        shiftC = busA[0];
      end
      3'd4: shiftQ = {busA[6:0], 1'b0};  // SLA
      3'd5: begin  // SRA
        shiftQ = {busA[7], busA[7:1]};
        shiftC = busA[0];
      end
      3'd6: begin
        if (Mode == 3) begin
          shiftQ = {busA[3:0], busA[7:4]};  // Nibble swap
          shiftC = 1'b0;
        end else begin
          shiftQ = {busA[6:0], 1'b1};       // SLL
        end
      end
      3'd7: begin  // SRL
        shiftQ = {1'b0, busA[7:1]};
        shiftC = busA[0];
      end
      default: ;
    endcase
  end

  // Decimal adjust, direction from N
  always_comb begin
    daaQ = {1'b0, busA};
    daaH = fIn[aluPkg::flagH];
    if (!fIn[aluPkg::flagN]) begin
      if (daaQ[3:0] > 4'd9 || fIn[aluPkg::flagH]) begin
        daaH = (daaQ[3:0] > 4'd9);
        daaQ = daaQ + 9'd6;
      end
      if (daaQ[8:4] > 5'd9 || fIn[aluPkg::flagC])
        daaQ = daaQ + 9'd96;
    end else begin
      if (daaQ[3:0] > 4'd9 || fIn[aluPkg::flagH]) begin
        if (daaQ[3:0] > 4'd5)
          daaH = 1'b0;
        daaQ[7:0] = daaQ[7:0] - 8'd6;
      end
      if (busA > 8'd153 || fIn[aluPkg::flagC])
        daaQ = daaQ - 9'd352;
    end
  end

  always_comb begin
    q     = '0;
    flags = fIn;
    case (cmd_i.op)
      aluPkg::opShift: begin
        q     = shiftQ;
        flags = resFlags(q, fIn);
        flags[aluPkg::flagC] = shiftC;
        flags[aluPkg::flagH] = 1'b0;
        flags[aluPkg::flagN] = 1'b0;
        if (cmd_i.iSet == 2'b00) begin  // Accumulator rotates keep S, Z, P
          flags[aluPkg::flagS] = fIn[aluPkg::flagS];
          flags[aluPkg::flagZ] = fIn[aluPkg::flagZ];
          flags[aluPkg::flagP] = fIn[aluPkg::flagP];
        end
      end
      aluPkg::opBit: begin
        q = busB & mask;
        flags[aluPkg::flagS] = q[7];
        flags[aluPkg::flagZ] = (q == 8'h00);
        flags[aluPkg::flagP] = (q == 8'h00);
        flags[aluPkg::flagH] = 1'b1;
        flags[aluPkg::flagN] = 1'b0;
        // Memory operand hides X and Y
        flags[aluPkg::flagX] = (cmd_i.ir[2:0] == 3'd6) ? 1'b0 : busB[3];
        flags[aluPkg::flagY] = (cmd_i.ir[2:0] == 3'd6) ? 1'b0 : busB[5];
      end
      aluPkg::opSet: q = busB | mask;
      aluPkg::opRes: q = busB & ~mask;
      aluPkg::opDaa: begin
        q     = daaQ[7:0];
        flags = resFlags(q, fIn);
        flags[aluPkg::flagH] = daaH;
        flags[aluPkg::flagC] = fIn[aluPkg::flagC] | daaQ[8];
      end
      aluPkg::opRld, aluPkg::opRrd: begin
        q     = {busA[7:4], cmd_i.op[0] ? busB[7:4] : busB[3:0]};
        flags = resFlags(q, fIn);
        flags[aluPkg::flagH] = 1'b0;
        flags[aluPkg::flagN] = 1'b0;
      end
      default: ;
    endcase
  end

  assign res_o.q     = q;
  assign res_o.flags = flags;

endmodule

/* verilog/aluCore.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational ALU core, steers by opcode group
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module aluCore #(
  parameter int Mode = 0
) (
  input  aluPkg::aluReq_t    cmd_i,
  output aluPkg::aluResult_t res_o
);

  aluPkg::aluResult_t arithRes;
  aluPkg::aluResult_t bitRes;

  aluArith arith0 (
    .cmd_i (cmd_i),
    .res_o (arithRes)
  );

  aluBitShift #(
    .Mode (Mode)
  ) bitShift0 (
    .cmd_i (cmd_i),
    .res_o (bitRes)
  );

  always_comb begin
    if (!cmd_i.op[3]) begin
      res_o = arithRes;              // opAdd to opCp
    end else if (cmd_i.op != 4'hF) begin
      res_o = bitRes;
    end else begin
      // Undefined opcode passes the flags through
      res_o.q     = '0;
      res_o.flags = cmd_i.flagsIn;
    end
  end

endmodule

/* verilog/aluPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU data types, flag bit positions, opcodes
// Request and result structs for the ALU unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package aluPkg;

  typedef logic [7:0] byte_t;    // Operands, results and flag bytes
  typedef logic [3:0] aluOp_t;
  typedef logic [5:0] irField_t; // [5:3] bit index or shift kind, [2:0] operand source
  typedef logic [1:0] iSet_t;    // 0 is the unprefixed set

  // Bit positions inside the flag byte
  localparam int flagC = 0;
  localparam int flagN = 1;
  localparam int flagP = 2;  // Parity or overflow
  localparam int flagX = 3;
  localparam int flagH = 4;
  localparam int flagY = 5;
  localparam int flagZ = 6;
  localparam int flagS = 7;

  // Arithmetic and logic group
  localparam aluOp_t opAdd = 4'h0;
  localparam aluOp_t opAdc = 4'h1;
  localparam aluOp_t opSub = 4'h2;
  localparam aluOp_t opSbc = 4'h3;
  localparam aluOp_t opAnd = 4'h4;
  localparam aluOp_t opXor = 4'h5;
  localparam aluOp_t opOr  = 4'h6;
  localparam aluOp_t opCp  = 4'h7;

  // Bit, shift and decimal group, 4'hF is undefined
  localparam aluOp_t opShift = 4'h8;
  localparam aluOp_t opBit   = 4'h9;
  localparam aluOp_t opSet   = 4'hA;
  localparam aluOp_t opRes   = 4'hB;
  localparam aluOp_t opDaa   = 4'hC;
  localparam aluOp_t opRld   = 4'hD;
  localparam aluOp_t opRrd   = 4'hE;

  typedef struct packed {
    aluOp_t   op;
    irField_t ir;
    iSet_t    iSet;
    logic     arith16; // Keep S, Z and P for 16-bit sequences
    logic     z16;     // Keep Z on a zero result
    byte_t    busA;
    byte_t    busB;
    byte_t    flagsIn;
  } aluReq_t;

  typedef struct packed {
    byte_t q;
    byte_t flags;
  } aluResult_t;

endpackage

/* verilog/aluUnit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU top with four-phase req/ack capture stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module aluUnit #(
  parameter int Mode = 0  // 3 selects the nibble swap variant
) (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               req_i,
  input  aluPkg::aluReq_t    cmd_i,
  output logic               ack_o,
  output aluPkg::aluResult_t res_o
);

  aluPkg::aluResult_t coreRes;
  logic               capture;

  aluCore #(
    .Mode (Mode)
  ) core0 (
    .cmd_i (cmd_i),
    .res_o (coreRes)
  );

  // New request only while the previous ack has been withdrawn
  assign capture = req_i & ~ack_o;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_o <= 1'b0;
      res_o <= '0;
    end else begin
      if (capture) begin
        res_o <= coreRes;  // Held until the next request
        ack_o <= 1'b1;
      end else if (!req_i) begin
        ack_o <= 1'b0;     // Requester finished its half
      end
    end
  end

endmodule

/* vlog.f */
+incdir+verification
verilog/aluPkg.sv
verilog/aluArith.sv
verilog/aluBitShift.sv
verilog/aluCore.sv
verilog/aluUnit.sv
verification/tbAluUnit.sv
